/* source/kbd_soc_pkg.sv */
package kbd_soc_pkg;

    // Bus and payload widths
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  col_t;
    typedef logic [4:0]  button_t;
    typedef logic [1:0]  app_t;
    typedef logic [7:0]  scr_byte_t;

    // Screen write cycle states
    typedef enum logic [2:0] {
        SCR_IDLE,
        SCR_SETUP,
        SCR_STROBE_LOW,
        SCR_STROBE_HIGH,
        SCR_FINISH
    } scr_state_t;

    // Address map
    localparam int unsigned RAM_WORDS    = 64;
    localparam addr_t       RAM_BASE     = 32'h0000_0000;
    localparam addr_t       KEYPAD_ADDR  = 32'h0000_1000;
    localparam addr_t       DISPLAY_ADDR = 32'h0000_2000;

    // Keypad timing and mode key
    localparam int SCAN_DIV = 8;
    localparam int MODE_KEY = 15;

    // 8080 strobe timing and LCD commands
    localparam int        WRX_LOW_CYC  = 2;
    localparam int        WRX_HIGH_CYC = 2;
    localparam scr_byte_t CMD_CASET    = 8'h2A;
    localparam scr_byte_t CMD_RASET    = 8'h2B;
    localparam scr_byte_t CMD_RAMWR    = 8'h2C;

endpackage

/* source/column_scanner.sv */
`timescale 1ns/1ps

module column_scanner
    import kbd_soc_pkg::*;
(
    input  logic clk,
    input  logic rst,
    output col_t column,
    output logic scan_tick
);

    logic [$clog2(SCAN_DIV)-1:0] dwell_cnt;

    // Last cycle of the dwell, rows have settled by now
    assign scan_tick = (dwell_cnt == SCAN_DIV - 1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dwell_cnt <= '0;
        end else if (scan_tick) begin
            dwell_cnt <= '0;
        end else begin
            dwell_cnt <= dwell_cnt + 1'b1;
        end
    end

    // One-hot rotation, column 0 first
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            column <= 4'b0001;
        end else if (scan_tick) begin
            column <= {column[2:0], column[3]};
        end
    end

endmodule

/* source/keypad_decoder.sv */
`timescale 1ns/1ps

module keypad_decoder
    import kbd_soc_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  col_t    column,
    input  col_t    row,
    input  logic    scan_tick,
    output button_t button,
    output app_t    app,
    output logic    key_rise
);

    logic [1:0] col_idx;
    logic [1:0] row_idx;
    logic [3:0] cur_code;
    logic [3:0] hit_code;
    logic [3:0] sweep_code;
    logic       row_hit;
    logic       sweep_hit;
    logic       sweep_any;
    logic       prev_hit;

    // Column index from the one-hot drive, lowest active row wins
    always_comb begin
        col_idx = '0;
        row_idx = '0;
        for (int i = 3; i >= 0; i--) begin
            if (column[i]) begin
                col_idx = i[1:0];
            end
        end
        for (int i = 3; i >= 0; i--) begin
            if (row[i]) begin
                row_idx = i[1:0];
            end
        end
    end

    assign row_hit  = |row;
    assign cur_code = {col_idx, row_idx};

    // Include the hit seen on the closing tick itself
    assign sweep_any  = sweep_hit | row_hit;
    assign sweep_code = row_hit ? cur_code : hit_code;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            button    <= '0;
            app       <= '0;
            key_rise  <= 1'b0;
            hit_code  <= '0;
            sweep_hit <= 1'b0;
            prev_hit  <= 1'b0;
        end else begin
            key_rise <= 1'b0;
            if (scan_tick && column[3]) begin
                // End of sweep
                if (!sweep_any) begin
                    button <= '0;
                end else if (!prev_hit) begin
                    button   <= {1'b1, sweep_code};
                    key_rise <= 1'b1;
                    if (sweep_code == 4'(MODE_KEY)) begin
                        app <= app + 1'b1;
                    end
                end
                prev_hit  <= sweep_any;
                sweep_hit <= 1'b0;
            end else if (scan_tick && row_hit) begin
                sweep_hit <= 1'b1;
                hit_code  <= cur_code;
            end
        end
    end

endmodule

/* source/data_ram.sv */
`timescale 1ns/1ps

module data_ram
    import kbd_soc_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       ram_req,
    input  logic       ram_we,
    input  logic [5:0] ram_index,
    input  word_t      ram_wdata,
    output word_t      ram_rdata,
    output logic       ram_ack
);

    word_t mem [RAM_WORDS];

    always_ff @(posedge clk) begin
        if (ram_req) begin
            if (ram_we) begin
                mem[ram_index] <= ram_wdata;
            end else begin
                ram_rdata <= mem[ram_index];
            end
        end
    end

    // Every access completes in one cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ram_ack <= 1'b0;
        end else begin
            ram_ack <= ram_req;
        end
    end

endmodule

/* source/mmio_bridge.sv */
`timescale 1ns/1ps

module mmio_bridge
    import kbd_soc_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  addr_t      bus_addr,
    input  word_t      bus_wdata,
    input  logic       bus_read,
    input  logic       bus_write,
    output word_t      bus_rdata,
    output logic       bus_ack,
    output logic       ram_req,
    output logic       ram_we,
    output logic [5:0] ram_index,
    output word_t      ram_wdata,
    input  word_t      ram_rdata,
    input  logic       ram_ack,
    input  button_t    button,
    input  app_t       app,
    input  logic       key_rise,
    output logic       disp_wen,
    output scr_byte_t  disp_byte,
    output logic       disp_dc,
    input  logic       disp_ack
);

    logic    busy;
    logic    accept;
    logic    accept_q;
    logic    is_write;
    logic    dec_ram;
    logic    dec_key;
    logic    dec_disp;
    logic    sel_ram;
    logic    sel_key;
    logic    sel_disp;
    addr_t   ram_offset;
    logic    key_pending;
    button_t last_button;
    word_t   key_reg;
    word_t   local_rdata;
    logic    local_ack;

    assign accept = (bus_read | bus_write) & ~busy;

    // Region decode, display reads fall through to the local zero answer
    assign ram_offset = bus_addr - RAM_BASE;
    assign dec_ram    = (bus_addr >= RAM_BASE) && (ram_offset < RAM_WORDS * 4);
    assign dec_key    = (bus_addr == KEYPAD_ADDR);
    assign dec_disp   = bus_write && (bus_addr == DISPLAY_ADDR);

    // Master holds address and data until ack
    assign ram_index = ram_offset[7:2];
    assign ram_wdata = bus_wdata;
    assign ram_we    = is_write;
    assign ram_req   = accept_q & sel_ram;
    assign disp_byte = bus_wdata[7:0];
    assign disp_dc   = bus_wdata[8];

    assign key_reg = {key_pending, 21'b0, app, 3'b0, last_button};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy     <= 1'b0;
            accept_q <= 1'b0;
            is_write <= 1'b0;
            sel_ram  <= 1'b0;
            sel_key  <= 1'b0;
            sel_disp <= 1'b0;
        end else begin
            accept_q <= accept;
            if (accept) begin
                busy     <= 1'b1;
                is_write <= bus_write;
                sel_ram  <= dec_ram;
                sel_key  <= dec_key;
                sel_disp <= dec_disp;
            end else if (bus_ack) begin
                busy <= 1'b0;
            end
        end
    end

    // Local answers and the display strobe, one cycle after the decode
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            disp_wen    <= 1'b0;
            local_ack   <= 1'b0;
            local_rdata <= '0;
        end else begin
            disp_wen  <= accept_q & sel_disp;
            local_ack <= accept_q & ~sel_ram & ~sel_disp;
            if (accept_q) begin
                local_rdata <= (sel_key && !is_write) ? key_reg : '0;
            end
        end
    end

    // Pending flag, a new press beats a clearing read
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            key_pending <= 1'b0;
            last_button <= '0;
        end else begin
            if (key_rise) begin
                key_pending <= 1'b1;
                last_button <= button;
            end else if (accept_q && sel_key && !is_write) begin
                key_pending <= 1'b0;
            end
        end
    end

    assign bus_ack   = local_ack | (sel_ram & ram_ack) | (sel_disp & disp_ack);
    assign bus_rdata = sel_ram ? ram_rdata : local_rdata;

endmodule

/* source/screen_driver.sv */
`timescale 1ns/1ps

module screen_driver
    import kbd_soc_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      disp_wen,
    input  scr_byte_t disp_byte,
    input  logic      disp_dc,
    output logic      disp_ack,
    output logic      csx,
    output logic      dcx,
    output logic      wrx,
    output scr_byte_t screen_data,
    output logic      check_x,
    output logic      check_y,
    output logic      check_c
);

    scr_state_t state;
    logic [$clog2(WRX_LOW_CYC + WRX_HIGH_CYC)-1:0] phase;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= SCR_IDLE;
            phase       <= '0;
            csx         <= 1'b1;
            wrx         <= 1'b1;
            dcx         <= 1'b1;
            screen_data <= '0;
            disp_ack    <= 1'b0;
        end else begin
            disp_ack <= 1'b0;
            case (state)
                SCR_IDLE: begin
                    if (disp_wen) begin
                        // Select the chip and present dcx and data for setup
                        csx         <= 1'b0;
                        dcx         <= disp_dc;
                        screen_data <= disp_byte;
                        state       <= SCR_SETUP;
                    end
                end
                SCR_SETUP: begin
                    wrx   <= 1'b0;
                    phase <= '0;
                    state <= SCR_STROBE_LOW;
                end
                SCR_STROBE_LOW: begin
                    if (phase == WRX_LOW_CYC - 1) begin
                        // Rising wrx latches the byte in the controller
                        wrx   <= 1'b1;
                        phase <= '0;
                        state <= SCR_STROBE_HIGH;
                    end else begin
                        phase <= phase + 1'b1;
                    end
                end
                SCR_STROBE_HIGH: begin
                    if (phase == WRX_HIGH_CYC - 1) begin
                        csx      <= 1'b1;
                        disp_ack <= 1'b1;
                        state    <= SCR_FINISH;
                    end else begin
                        phase <= phase + 1'b1;
                    end
                end
                SCR_FINISH: begin
                    state <= SCR_IDLE;
                end
                default: begin
                    state <= SCR_IDLE;
                end
            endcase
        end
    end

    // Sticky flags, set once a matching command byte has gone out
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            check_x <= 1'b0;
            check_y <= 1'b0;
            check_c <= 1'b0;
        end else if (state == SCR_STROBE_HIGH && phase == WRX_HIGH_CYC - 1 && !dcx) begin
            if (screen_data == CMD_CASET) begin
                check_x <= 1'b1;
            end
            if (screen_data == CMD_RASET) begin
                check_y <= 1'b1;
            end
            if (screen_data == CMD_RAMWR) begin
                check_c <= 1'b1;
            end
        end
    end

endmodule

/* source/kbd_soc_top.sv */
`timescale 1ns/1ps

module kbd_soc_top
    import kbd_soc_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  col_t      row,
    output col_t      column,
    input  addr_t     bus_addr,
    input  word_t     bus_wdata,
    input  logic      bus_read,
    input  logic      bus_write,
    output word_t     bus_rdata,
    output logic      bus_ack,
    output logic      screen_csx,
    output logic      screen_dcx,
    output logic      screen_wrx,
    output scr_byte_t screen_data,
    output logic      check_x,
    output logic      check_y,
    output logic      check_c
);

    // Keypad path
    logic    scan_tick;
    button_t button;
    app_t    app;
    logic    key_rise;

    // RAM port
    logic       ram_req;
    logic       ram_we;
    logic [5:0] ram_index;
    word_t      ram_wdata;
    word_t      ram_rdata;
    logic       ram_ack;

    // Display port
    logic      disp_wen;
    scr_byte_t disp_byte;
    logic      disp_dc;
    logic      disp_ack;

    column_scanner i_column_scanner (
        .clk       (clk),
        .rst       (rst),
        .column    (column),
        .scan_tick (scan_tick)
    );

    keypad_decoder i_keypad_decoder (
        .clk       (clk),
        .rst       (rst),
        .column    (column),
        .row       (row),
        .scan_tick (scan_tick),
        .button    (button),
        .app       (app),
        .key_rise  (key_rise)
    );

    mmio_bridge i_mmio_bridge (
        .clk       (clk),
        .rst       (rst),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_read  (bus_read),
        .bus_write (bus_write),
        .bus_rdata (bus_rdata),
        .bus_ack   (bus_ack),
        .ram_req   (ram_req),
        .ram_we    (ram_we),
        .ram_index (ram_index),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata),
        .ram_ack   (ram_ack),
        .button    (button),
        .app       (app),
        .key_rise  (key_rise),
        .disp_wen  (disp_wen),
        .disp_byte (disp_byte),
        .disp_dc   (disp_dc),
        .disp_ack  (disp_ack)
    );

    data_ram i_data_ram (
        .clk       (clk),
        .rst       (rst),
        .ram_req   (ram_req),
        .ram_we    (ram_we),
        .ram_index (ram_index),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata),
        .ram_ack   (ram_ack)
    );

    screen_driver i_screen_driver (
        .clk         (clk),
        .rst         (rst),
        .disp_wen    (disp_wen),
        .disp_byte   (disp_byte),
        .disp_dc     (disp_dc),
        .disp_ack    (disp_ack),
        .csx         (screen_csx),
        .dcx         (screen_dcx),
        .wrx         (screen_wrx),
        .screen_data (screen_data),
        .check_x     (check_x),
        .check_y     (check_y),
        .check_c     (check_c)
    );

endmodule

/* dv/kbd_soc_checks.svh */
`ifndef KBD_SOC_CHECKS_SVH
`define KBD_SOC_CHECKS_SVH

// Error counts for the closing line
int checks_done;
int value_errors;
int protocol_errors;

// Fibonacci LFSR, taps 32 22 2 1
logic [31:0] lfsr_state = 32'h0911_1c00;

// Expected RAM contents and which words hold a known value
word_t ref_ram [RAM_WORDS];
logic  ref_written [RAM_WORDS];

// One LFSR step per bit taken, first bit ends up as the MSB
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] result;
    logic        fb;
    result = '0;
    for (int i = 0; i < n; i++) begin
        fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        result     = {result[30:0], fb};
    end
    return result;
endfunction

// Keypad register: pending in bit 31, mode in 9:8, button in 4:0
function automatic word_t keypad_reg_model(input logic pending, input app_t mode,
                                           input button_t btn);
    word_t w;
    w      = '0;
    w[31]  = pending;
    w[9:8] = mode;
    w[4:0] = btn;
    return w;
endfunction

// Flags as {c, y, x}, only command bytes count
function automatic logic [2:0] flags_model(input logic [2:0] flags, input logic dc,
                                           input scr_byte_t b);
    logic [2:0] next;
    next = flags;
    if (!dc) begin
        if (b == 8'h2A) begin
            next[0] = 1'b1;
        end
        if (b == 8'h2B) begin
            next[1] = 1'b1;
        end
        if (b == 8'h2C) begin
            next[2] = 1'b1;
        end
    end
    return next;
endfunction

task automatic compare_word(input string name, input word_t got, input word_t exp);
    checks_done++;
    if (got !== exp) begin
        value_errors++;
        $display("Error %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
endtask

task automatic compare_button(input string name, input button_t got, input button_t exp);
    checks_done++;
    if (got !== exp) begin
        value_errors++;
        $display("Error %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
endtask

task automatic compare_app(input string name, input app_t got, input app_t exp);
    checks_done++;
    if (got !== exp) begin
        value_errors++;
        $display("Error %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
endtask

task automatic compare_scr_byte(input string name, input scr_byte_t got,
                                input scr_byte_t exp);
    checks_done++;
    if (got !== exp) begin
        value_errors++;
        $display("Error %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
endtask

task automatic compare_col(input string name, input col_t got, input col_t exp);
    checks_done++;
    if (got !== exp) begin
        value_errors++;
        $display("Error %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
endtask

task automatic compare_bit(input string name, input logic got, input logic exp);
    checks_done++;
    if (got !== exp) begin
        value_errors++;
        $display("Error %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
endtask

`endif

/* dv/tb_kbd_soc.sv */
`timescale 1ns/1ps

module tb_kbd_soc
    import kbd_soc_pkg::*;
();

    localparam int RESET_CYC   = 16;
    localparam int SWEEP_CYC   = 4 * SCAN_DIV;
    localparam int PRESS_CYC   = 5 * SWEEP_CYC;
    localparam int N_RAM       = 40;
    localparam int N_DISP      = 16;
    localparam int OP_CYC      = 5;
    localparam int DISP_OP_CYC = 11;
    localparam int ACK_LIMIT   = 20;
    // Operations per test times worst case cycles each, doubled
    localparam int TIMEOUT_CYC = 2 * (RESET_CYC + OP_CYC + 2 * N_RAM * OP_CYC
        + 15 * (PRESS_CYC + 2 * OP_CYC) + 5 * (PRESS_CYC + OP_CYC)
        + (N_DISP + 6) * DISP_OP_CYC);

    logic      clk;
    logic      rst;
    col_t      row;
    col_t      column;
    addr_t     bus_addr;
    word_t     bus_wdata;
    logic      bus_read;
    logic      bus_write;
    word_t     bus_rdata;
    logic      bus_ack;
    logic      screen_csx;
    logic      screen_dcx;
    logic      screen_wrx;
    scr_byte_t screen_data;
    logic      check_x;
    logic      check_y;
    logic      check_c;

    // Keypad model state
    logic       key_down;
    logic [3:0] key_num;

    int         cycle_cnt;
    int         wrx_pulses;
    logic [9:0] scr_seen [$];
    logic [9:0] scr_expect [$];
    logic [2:0] exp_flags;
    app_t       exp_app;

    `include "kbd_soc_checks.svh"

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // Row of the held key is high while its column is driven
    assign row = (key_down && column[key_num[3:2]]) ? (4'b0001 << key_num[1:0]) : 4'b0000;

    kbd_soc_top i_kbd_soc_top (
        .clk         (clk),
        .rst         (rst),
        .row         (row),
        .column      (column),
        .bus_addr    (bus_addr),
        .bus_wdata   (bus_wdata),
        .bus_read    (bus_read),
        .bus_write   (bus_write),
        .bus_rdata   (bus_rdata),
        .bus_ack     (bus_ack),
        .screen_csx  (screen_csx),
        .screen_dcx  (screen_dcx),
        .screen_wrx  (screen_wrx),
        .screen_data (screen_data),
        .check_x     (check_x),
        .check_y     (check_y),
        .check_c     (check_c)
    );

    // Screen monitor, one entry per wrx strobe
    always @(negedge screen_wrx) begin
        if (!rst) begin
            wrx_pulses++;
            scr_seen.push_back({screen_csx, screen_dcx, screen_data});
        end
    end

    // Match strobes against the bus writes in order
    always @(negedge clk) begin : screen_compare
        logic [9:0] seen;
        logic [9:0] want;
        if (scr_seen.size() > 0) begin
            seen = scr_seen.pop_front();
            if (scr_expect.size() == 0) begin
                protocol_errors++;
                $display("Screen strobe seen with no display write pending at %0t", $time);
            end else begin
                want = scr_expect.pop_front();
                compare_bit("screen_csx", seen[9], want[9]);
                compare_bit("screen_dcx", seen[8], want[8]);
                compare_scr_byte("screen_data", seen[7:0], want[7:0]);
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYC) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Latency counts clock cycles from the first cycle of the request
    task automatic bus_access(input logic write, input addr_t addr, input word_t wdata,
                              output word_t rdata, output int latency);
        int cyc;
        cyc   = 0;
        rdata = '0;
        @(posedge clk);
        bus_addr  <= addr;
        bus_wdata <= wdata;
        bus_read  <= !write;
        bus_write <= write;
        @(negedge clk);
        while (!bus_ack && cyc < ACK_LIMIT) begin
            @(negedge clk);
            cyc++;
        end
        if (bus_ack) begin
            rdata   = bus_rdata;
            latency = cyc;
        end else begin
            protocol_errors++;
            $display("No bus_ack within %0d cycles for address %h", ACK_LIMIT, addr);
            latency = -1;
        end
        @(posedge clk);
        bus_read  <= 1'b0;
        bus_write <= 1'b0;
    endtask

    task automatic check_latency(input string what, input int got, input int exp);
        if (got >= 0 && got != exp) begin
            protocol_errors++;
            $display("%s acknowledged after %0d cycles instead of %0d", what, got, exp);
        end
    endtask

    task automatic read_keypad(output word_t value);
        int lat;
        bus_access(1'b0, KEYPAD_ADDR, '0, value, lat);
        check_latency("Keypad read", lat, 2);
    endtask

    // Hold three sweeps, release two
    task automatic press_key(input int k);
        @(posedge clk);
        key_num  <= k[3:0];
        key_down <= 1'b1;
        repeat (3 * SWEEP_CYC) @(posedge clk);
        key_down <= 1'b0;
        repeat (2 * SWEEP_CYC) @(posedge clk);
    endtask

    task automatic display_write(input logic dc, input scr_byte_t data);
        word_t unused_rdata;
        int    lat;
        scr_expect.push_back({1'b0, dc, data});
        bus_access(1'b1, DISPLAY_ADDR, {23'b0, dc, data}, unused_rdata, lat);
        check_latency("Display write", lat, 8);
        exp_flags = flags_model(exp_flags, dc, data);
        @(negedge clk);
        compare_bit("check_x", check_x, exp_flags[0]);
        compare_bit("check_y", check_y, exp_flags[1]);
        compare_bit("check_c", check_c, exp_flags[2]);
    endtask

    initial begin
        word_t     rdata;
        word_t     wdata;
        int        lat;
        int        idx;
        int        pulses_before;
        logic      dc;
        scr_byte_t b;

        rst             = 1'b1;
        bus_addr        = '0;
        bus_wdata       = '0;
        bus_read        = 1'b0;
        bus_write       = 1'b0;
        key_down        = 1'b0;
        key_num         = '0;
        cycle_cnt       = 0;
        wrx_pulses      = 0;
        checks_done     = 0;
        value_errors    = 0;
        protocol_errors = 0;
        exp_flags       = '0;
        exp_app         = '0;
        for (int i = 0; i < RAM_WORDS; i++) begin
            ref_written[i] = 1'b0;
        end
        repeat (RESET_CYC) @(posedge clk);
        rst <= 1'b0;

        // Reset state
        @(negedge clk);
        compare_bit("screen_csx", screen_csx, 1'b1);
        compare_bit("screen_wrx", screen_wrx, 1'b1);
        compare_bit("bus_ack", bus_ack, 1'b0);
        compare_col("column", column, 4'b0001);
        compare_bit("check_x", check_x, 1'b0);
        compare_bit("check_y", check_y, 1'b0);
        compare_bit("check_c", check_c, 1'b0);
        read_keypad(rdata);
        compare_word("bus_rdata keypad", rdata, '0);

        // RAM, random indices then read back all written words
        for (int n = 0; n < N_RAM; n++) begin
            idx              = int'(rand_bits(6));
            wdata            = rand_bits(32);
            ref_ram[idx]     = wdata;
            ref_written[idx] = 1'b1;
            bus_access(1'b1, RAM_BASE + addr_t'(idx * 4), wdata, rdata, lat);
            check_latency("RAM write", lat, 2);
        end
        for (int i = 0; i < RAM_WORDS; i++) begin
            if (ref_written[i]) begin
                bus_access(1'b0, RAM_BASE + addr_t'(i * 4), '0, rdata, lat);
                check_latency("RAM read", lat, 2);
                compare_word("bus_rdata ram", rdata, ref_ram[i]);
            end
        end

        // Keys 0 to 14, second read finds pending clear
        for (int k = 0; k < 15; k++) begin
            press_key(k);
            read_keypad(rdata);
            compare_word("bus_rdata keypad", rdata,
                         keypad_reg_model(1'b1, exp_app, {1'b1, k[3:0]}));
            compare_button("button field", rdata[4:0], {1'b1, k[3:0]});
            read_keypad(rdata);
            compare_word("bus_rdata keypad reread", rdata,
                         keypad_reg_model(1'b0, exp_app, {1'b1, k[3:0]}));
        end

        // Mode key steps the application mode
        for (int p = 1; p <= 5; p++) begin
            press_key(MODE_KEY);
            exp_app = app_t'(p % 4);
            read_keypad(rdata);
            compare_app("app field", rdata[9:8], exp_app);
            compare_word("bus_rdata keypad", rdata,
                         keypad_reg_model(1'b1, exp_app, {1'b1, 4'hF}));
        end

        // Random display writes
        pulses_before = wrx_pulses;
        for (int n = 0; n < N_DISP; n++) begin
            wdata = rand_bits(9);
            dc    = wdata[8];
            b     = wdata[7:0];
            // Keep the flag commands for the next test
            if (!dc && b >= 8'h2A && b <= 8'h2C) begin
                b = b ^ 8'h80;
            end
            display_write(dc, b);
        end
        @(negedge clk);
        if (wrx_pulses - pulses_before != N_DISP || scr_expect.size() != 0) begin
            protocol_errors++;
            $display("Saw %0d wrx pulses for %0d display writes",
                     wrx_pulses - pulses_before, N_DISP);
        end

        // Flag bytes as data first, then as commands
        for (int pass = 0; pass < 2; pass++) begin
            for (int c = 0; c < 3; c++) begin
                display_write(pass == 0, 8'h2A + scr_byte_t'(c));
            end
        end

        repeat (4) @(posedge clk);
        $display("Checks: %0d, value errors: %0d, protocol errors: %0d",
                 checks_done, value_errors, protocol_errors);
        if (value_errors + protocol_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+dv
source/kbd_soc_pkg.sv
source/column_scanner.sv
source/keypad_decoder.sv
source/data_ram.sv
source/mmio_bridge.sv
source/screen_driver.sv
source/kbd_soc_top.sv
dv/tb_kbd_soc.sv

/* Bender.yml */
package:
  name: kbd_soc

sources:
  - source/kbd_soc_pkg.sv
  - source/column_scanner.sv
  - source/keypad_decoder.sv
  - source/data_ram.sv
  - source/mmio_bridge.sv
  - source/screen_driver.sv
  - source/kbd_soc_top.sv
